// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = wbb_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== flist.f ====
wbb_pkg.sv
wbb_prio_encoder.sv
wbb_victim_buffer.sv
wbb_tag_counter.sv
wbb_ctrl.sv
wbb_top.sv
wbb_checker.sv
wbb_tb.sv

// ==== wbb_checker.sv ====
// Bound into wbb_top; reads the controller state register u_ctrl.state_q, idle during reset
`timescale 1ns/100ps

module wbb_checker (
  input logic                            clk_i,
  input logic                            rst_ni,
  input logic                            l2_req_valid_i,
  input logic                            l2_req_ready_i,
  input logic [wbb_pkg::LINE_ADDR_W-1:0] l2_req_addr_i,
  input logic [wbb_pkg::LINE_W-1:0]      l2_req_line_i,
  input logic [wbb_pkg::WBB_TAG_W-1:0]   l2_req_tag_i,
  input logic                            evict_ready_i,
  input logic                            l2_ack_ready_i,
  // add, switch, mark, clear, wake
  input logic [4:0]                      strobes_i,
  input wbb_pkg::wbb_state_e             state_i
);

  // Request held until L2 takes it
  req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (l2_req_valid_i && !l2_req_ready_i) |=> (l2_req_valid_i && $stable(l2_req_addr_i) &&
      $stable(l2_req_line_i) && $stable(l2_req_tag_i)))
    else $error("L2 request dropped or changed under back-pressure");

  // One buffer operation per cycle
  one_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(strobes_i))
    else $error("More than one buffer strobe high in a cycle");

  // No handshakes accepted while a request is out
  issue_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i == wbb_pkg::ISSUE) |-> (!evict_ready_i && !l2_ack_ready_i))
    else $error("Ready output high in ISSUE");

endmodule

bind wbb_top wbb_checker u_checker (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .l2_req_valid_i (l2_req_valid_o),
  .l2_req_ready_i (l2_req_ready_i),
  .l2_req_addr_i  (l2_req_addr_o),
  .l2_req_line_i  (l2_req_line_o),
  .l2_req_tag_i   (l2_req_tag_o),
  .evict_ready_i  (evict_ready_o),
  .l2_ack_ready_i (l2_ack_ready_o),
  .strobes_i      ({add_entry, switch_entry, mark_wait, clear_entry, wake_entry}),
  .state_i        (u_ctrl.state_q)
);

// ==== wbb_ctrl.sv ====
// One operation per cycle; acks beat evictions, and nothing else moves while a request is in ISSUE
`timescale 1ns/100ps

module wbb_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  // Handshake inputs
  input  logic evict_valid_i,
  input  logic l2_ack_valid_i,
  input  logic l2_ack_retry_i,
  input  logic l2_req_ready_i,
  // Buffer status
  input  logic line_hit_i,
  input  logic tag_hit_i,
  input  logic req_available_i,
  input  logic full_i,
  // Handshake outputs
  output logic evict_ready_o,
  output logic l2_ack_ready_o,
  output logic l2_req_valid_o,
  // Buffer strobes
  output logic add_entry_o,
  output logic switch_entry_o,
  output logic mark_wait_o,
  output logic clear_entry_o,
  output logic wake_entry_o
);

  wbb_pkg::wbb_state_e state_q;
  wbb_pkg::wbb_state_e state_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= wbb_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Decision logic
  always_comb begin
    state_d        = state_q;
    evict_ready_o  = 1'b0;
    l2_ack_ready_o = 1'b0;
    l2_req_valid_o = 1'b0;
    add_entry_o    = 1'b0;
    switch_entry_o = 1'b0;
    mark_wait_o    = 1'b0;
    clear_entry_o  = 1'b0;
    wake_entry_o   = 1'b0;

    case (state_q)
      wbb_pkg::IDLE: begin
        if (l2_ack_valid_i) begin
          // Ack always consumed; a stale tag just drops
          l2_ack_ready_o = 1'b1;
          if (tag_hit_i) begin
            clear_entry_o = !l2_ack_retry_i;
            wake_entry_o  = l2_ack_retry_i;
          end
        end else if (evict_valid_i && (line_hit_i || !full_i)) begin
          // A hit still fits when full, it reuses its own entry
          evict_ready_o  = 1'b1;
          switch_entry_o = line_hit_i;
          add_entry_o    = !line_hit_i;
        end else if (req_available_i) begin
          state_d = wbb_pkg::ISSUE;
        end
      end

      wbb_pkg::ISSUE: begin
        // Buffer frozen here, so the request stays stable
        l2_req_valid_o = 1'b1;
        if (l2_req_ready_i) begin
          mark_wait_o = 1'b1;
          state_d     = wbb_pkg::IDLE;
        end
      end

      default: begin
        state_d = wbb_pkg::IDLE;
      end
    endcase
  end

endmodule

// ==== wbb_pkg.sv ====
// Assumes four entries and eight wrapping tags; a stale tag must retire before its value reissues
package wbb_pkg;

  // Buffer geometry
  // Number of victim entries held at once
  localparam int WBB_ENTRIES = 4;
  // Entry index width, matches WBB_ENTRIES
  localparam int WBB_IDX_W = 2;

  // Cache line payload
  localparam int LINE_W = 64;
  // Line address, byte offset already stripped
  localparam int LINE_ADDR_W = 26;

  // L2 request tag
  // Eight tags for four entries, so an old tag has time to drain
  localparam int WBB_TAG_W = 3;

  // Free entry count, 0 up to WBB_ENTRIES
  localparam int WBB_CNT_W = 3;

  // Controller states
  // IDLE   handles acks, evictions, or decides to issue
  // ISSUE  holds one L2 write request until it is accepted
  typedef enum logic {
    IDLE  = 1'b0,
    ISSUE = 1'b1
  } wbb_state_e;

endpackage

// ==== wbb_prio_encoder.sv ====
// Returns the lowest set bit index; an all-zero vector also gives zero, so qualify with |vec_i
`timescale 1ns/100ps

module wbb_prio_encoder #(
  parameter int WIDTH = 4,
  parameter int IDX_W = 2
) (
  input  logic [WIDTH-1:0] vec_i,
  output logic [IDX_W-1:0] idx_o
);

  // Scan from the top down
  // Lower bits overwrite higher ones, so the lowest set bit wins
  always_comb begin
    idx_o = '0;
    for (int i = WIDTH - 1; i >= 0; i--) begin
      if (vec_i[i]) begin
        idx_o = IDX_W'(i);
      end
    end
  end

endmodule

// ==== wbb_tag_counter.sv ====
// Tags wrap after eight requests; no check that a reissued tag is no longer outstanding
`timescale 1ns/100ps

module wbb_tag_counter (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // High for one cycle per accepted L2 request
  input  logic                          advance_i,
  // Tag for the next request
  output logic [wbb_pkg::WBB_TAG_W-1:0] tag_o
);

  logic [wbb_pkg::WBB_TAG_W-1:0] tag_q;

  // First request after reset carries tag 0
  // Natural overflow gives the wraparound
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tag_q <= '0;
    end else if (advance_i) begin
      tag_q <= tag_q + 1'b1;
    end
  end

  // Held steady while a request waits for ready
  assign tag_o = tag_q;

endmodule

// ==== wbb_tb.sv ====
// Reads wbb_vectors.txt from the project root; L2 never acks on its own, all acks come from vectors
`timescale 1ns/100ps

module wbb_tb;

  // 26 vectors of seven hex words each
  localparam int NUM_WORDS  = 182;
  localparam int WAIT_LIMIT = 200;

  logic                            clk_i;
  logic                            rst_ni;
  logic                            evict_valid_i;
  logic [wbb_pkg::LINE_ADDR_W-1:0] evict_addr_i;
  logic [wbb_pkg::LINE_W-1:0]      evict_line_i;
  logic                            evict_ready_o;
  logic [wbb_pkg::LINE_ADDR_W-1:0] lookup_addr_i;
  logic                            lookup_hit_o;
  logic [wbb_pkg::LINE_W-1:0]      lookup_line_o;
  logic                            l2_req_valid_o;
  logic [wbb_pkg::LINE_ADDR_W-1:0] l2_req_addr_o;
  logic [wbb_pkg::LINE_W-1:0]      l2_req_line_o;
  logic [wbb_pkg::WBB_TAG_W-1:0]   l2_req_tag_o;
  logic                            l2_req_ready_i;
  logic                            l2_ack_valid_i;
  logic [wbb_pkg::WBB_TAG_W-1:0]   l2_ack_tag_i;
  logic                            l2_ack_retry_i;
  logic                            l2_ack_ready_o;
  logic                            full_o;
  logic [wbb_pkg::WBB_CNT_W-1:0]   free_entries_o;

  logic [63:0] vec_mem [NUM_WORDS];

  // Reference model of the entries
  logic [wbb_pkg::WBB_ENTRIES-1:0] m_valid;
  logic [wbb_pkg::WBB_ENTRIES-1:0] m_wait;
  logic [wbb_pkg::LINE_ADDR_W-1:0] m_addr    [wbb_pkg::WBB_ENTRIES];
  logic [wbb_pkg::LINE_W-1:0]      m_line    [wbb_pkg::WBB_ENTRIES];
  logic [wbb_pkg::WBB_TAG_W-1:0]   m_tag     [wbb_pkg::WBB_ENTRIES];
  logic [wbb_pkg::WBB_TAG_W-1:0]   m_old_tag [wbb_pkg::WBB_ENTRIES];
  // Tag the next L2 request should carry
  logic [wbb_pkg::WBB_TAG_W-1:0]   m_next_tag;

  wbb_top dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic stop_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("Error at time %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
      stop_run();
    end
  endtask

  // Lowest set bit index or -1 when none
  function automatic int lowest_set(input logic [wbb_pkg::WBB_ENTRIES-1:0] bits);
    int found;
    found = -1;
    for (int k = wbb_pkg::WBB_ENTRIES - 1; k >= 0; k--) begin
      if (bits[k]) begin
        found = k;
      end
    end
    return found;
  endfunction

  function automatic int find_addr(input logic [wbb_pkg::LINE_ADDR_W-1:0] addr);
    logic [wbb_pkg::WBB_ENTRIES-1:0] match;
    for (int k = 0; k < wbb_pkg::WBB_ENTRIES; k++) begin
      match[k] = m_valid[k] && (m_addr[k] == addr);
    end
    return lowest_set(match);
  endfunction

  // Only a waiting entry answers to its tag
  function automatic int find_tag(input logic [wbb_pkg::WBB_TAG_W-1:0] tag);
    logic [wbb_pkg::WBB_ENTRIES-1:0] match;
    for (int k = 0; k < wbb_pkg::WBB_ENTRIES; k++) begin
      match[k] = m_wait[k] && (m_tag[k] == tag);
    end
    return lowest_set(match);
  endfunction

  task automatic model_evict(input logic [wbb_pkg::LINE_ADDR_W-1:0] addr,
                             input logic [wbb_pkg::LINE_W-1:0] line);
    int idx;
    idx = find_addr(addr);
    if (idx >= 0) begin
      // In-place overwrite makes an in-flight tag stale
      if (m_wait[idx]) begin
        m_old_tag[idx] = m_tag[idx];
      end
      m_wait[idx] = 1'b0;
      m_line[idx] = line;
    end else if (lowest_set(~m_valid) < 0) begin
      $display("DUT accepted an eviction to a new address while the buffer was full");
      stop_run();
    end else begin
      idx = lowest_set(~m_valid);
      m_valid[idx] = 1'b1;
      m_wait[idx]  = 1'b0;
      m_addr[idx]  = addr;
      m_line[idx]  = line;
    end
  endtask

  // Polls a ready output from just after the falling edge
  task automatic wait_for_ready(input bit ack_port);
    int cycles;
    cycles = 0;
    #1;
    while (!(ack_port ? l2_ack_ready_o : evict_ready_o) && cycles < WAIT_LIMIT) begin
      @(negedge clk_i);
      #1;
      cycles++;
    end
    if (!(ack_port ? l2_ack_ready_o : evict_ready_o)) begin
      $display("Timeout: %s stayed low", ack_port ? "l2_ack_ready_o" : "evict_ready_o");
      stop_run();
    end
  endtask

  task automatic do_evict(input logic [wbb_pkg::LINE_ADDR_W-1:0] addr,
                          input logic [wbb_pkg::LINE_W-1:0] line);
    evict_valid_i = 1'b1;
    evict_addr_i  = addr;
    evict_line_i  = line;
    wait_for_ready(1'b0);
    model_evict(addr, line);
    @(posedge clk_i);
    @(negedge clk_i);
    evict_valid_i = 1'b0;
  endtask

  task automatic do_ack(input logic [wbb_pkg::WBB_TAG_W-1:0] tag, input logic retry);
    int idx;
    l2_ack_valid_i = 1'b1;
    l2_ack_tag_i   = tag;
    l2_ack_retry_i = retry;
    wait_for_ready(1'b1);
    idx = find_tag(tag);
    // No match means a stale tag that is dropped
    if (idx >= 0) begin
      m_wait[idx] = 1'b0;
      if (!retry) begin
        m_valid[idx] = 1'b0;
      end
    end
    @(posedge clk_i);
    @(negedge clk_i);
    l2_ack_valid_i = 1'b0;
    l2_ack_retry_i = 1'b0;
  endtask

  task automatic wait_until_waiting(input int idx);
    int cycles;
    cycles = 0;
    while (!m_wait[idx] && cycles < WAIT_LIMIT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!m_wait[idx]) begin
      $display("Timeout: entry %0d was never accepted by L2", idx);
      stop_run();
    end
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (lowest_set(m_valid & ~m_wait) >= 0 && cycles < WAIT_LIMIT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (lowest_set(m_valid & ~m_wait) >= 0) begin
      $display("Timeout: buffered entries were never sent to L2");
      stop_run();
    end
  endtask

  // L2 request side gives ready after 0 to 3 cycles
  initial begin : l2_responder
    int delay;
    int idx;
    void'($urandom(32'h1696e1ec));
    l2_req_ready_i = 1'b0;
    forever begin
      @(negedge clk_i);
      l2_req_ready_i = 1'b0;
      if (l2_req_valid_o) begin
        delay = $urandom_range(3, 0);
        repeat (delay) @(negedge clk_i);
        idx = lowest_set(m_valid & ~m_wait);
        if (idx < 0) begin
          $display("L2 request raised while no entry should be sendable");
          stop_run();
        end
        check_value("l2_req_addr_o", 64'(l2_req_addr_o), 64'(m_addr[idx]));
        check_value("l2_req_line_o", l2_req_line_o, m_line[idx]);
        check_value("l2_req_tag_o", 64'(l2_req_tag_o), 64'(m_next_tag));
        l2_req_ready_i = 1'b1;
        @(posedge clk_i);
        m_tag[idx]  = m_next_tag;
        m_wait[idx] = 1'b1;
        m_next_tag  = m_next_tag + 3'd1;
      end
    end
  end

  initial begin : run_vectors
    logic [63:0] field [7];
    int          base;
    int          idx;
    bit          done;
    rst_ni         = 1'b0;
    evict_valid_i  = 1'b0;
    evict_addr_i   = '0;
    evict_line_i   = '0;
    lookup_addr_i  = '0;
    l2_ack_valid_i = 1'b0;
    l2_ack_tag_i   = '0;
    l2_ack_retry_i = 1'b0;
    m_valid        = '0;
    m_wait         = '0;
    m_next_tag     = '0;
    $readmemh("wbb_vectors.txt", vec_mem);
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    // All entries free and nothing requested after reset
    check_value("free_entries_o", 64'(free_entries_o), 64'(wbb_pkg::WBB_ENTRIES));
    check_value("full_o", 64'(full_o), 64'd0);
    check_value("l2_req_valid_o", 64'(l2_req_valid_o), 64'd0);
    base = 0;
    done = 1'b0;
    // Fields are cmd sel addr data hit free full
    while (!done && base < NUM_WORDS) begin
      for (int f = 0; f < 7; f++) begin
        field[f] = vec_mem[base + f];
      end
      base += 7;
      case (field[0])
        64'h1: do_evict(field[2][wbb_pkg::LINE_ADDR_W-1:0], field[3]);
        64'h2: begin
          lookup_addr_i = field[2][wbb_pkg::LINE_ADDR_W-1:0];
          #1;
          check_value("lookup_hit_o", 64'(lookup_hit_o), field[4]);
          if (field[4] != 64'd0) begin
            check_value("lookup_line_o", lookup_line_o, field[3]);
          end
          @(negedge clk_i);
        end
        64'h3, 64'h4: begin
          idx = find_addr(field[2][wbb_pkg::LINE_ADDR_W-1:0]);
          if (idx < 0) begin
            $display("Ack vector names address 0x%0h, which the model does not hold", field[2]);
            stop_run();
          end else begin
            wait_until_waiting(idx);
            do_ack((field[1] != 64'd0) ? m_old_tag[idx] : m_tag[idx], field[0] == 64'h4);
          end
        end
        64'h5: wait_drained();
        64'h6: begin
          // New address while full is held off until entry sel is freed
          evict_valid_i = 1'b1;
          evict_addr_i  = field[2][wbb_pkg::LINE_ADDR_W-1:0];
          evict_line_i  = field[3];
          for (int c = 0; c < 6; c++) begin
            #1;
            check_value("evict_ready_o", 64'(evict_ready_o), 64'd0);
            @(negedge clk_i);
          end
          idx = int'(field[1][wbb_pkg::WBB_IDX_W-1:0]);
          wait_until_waiting(idx);
          do_ack(m_tag[idx], 1'b0);
          do_evict(field[2][wbb_pkg::LINE_ADDR_W-1:0], field[3]);
        end
        64'hf: done = 1'b1;
        default: begin
          $display("Unknown command 0x%0h in the vector file", field[0]);
          stop_run();
        end
      endcase
      if (!done) begin
        check_value("free_entries_o", 64'(free_entries_o), field[5]);
        check_value("full_o", 64'(full_o), field[6]);
      end
    end
    if (!done) begin
      $display("Vector file ran out without an end command");
      stop_run();
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

// ==== wbb_top.sv ====
// Cache inputs must hold until evict_ready_o; L2 must not ack a tag before its request is accepted
`timescale 1ns/100ps

module wbb_top (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // Cache eviction port
  input  logic                            evict_valid_i,
  input  logic [wbb_pkg::LINE_ADDR_W-1:0] evict_addr_i,
  input  logic [wbb_pkg::LINE_W-1:0]      evict_line_i,
  output logic                            evict_ready_o,
  // Cache lookup port
  input  logic [wbb_pkg::LINE_ADDR_W-1:0] lookup_addr_i,
  output logic                            lookup_hit_o,
  output logic [wbb_pkg::LINE_W-1:0]      lookup_line_o,
  // L2 request port
  output logic                            l2_req_valid_o,
  output logic [wbb_pkg::LINE_ADDR_W-1:0] l2_req_addr_o,
  output logic [wbb_pkg::LINE_W-1:0]      l2_req_line_o,
  output logic [wbb_pkg::WBB_TAG_W-1:0]   l2_req_tag_o,
  input  logic                            l2_req_ready_i,
  // L2 acknowledge port
  input  logic                            l2_ack_valid_i,
  input  logic [wbb_pkg::WBB_TAG_W-1:0]   l2_ack_tag_i,
  input  logic                            l2_ack_retry_i,
  output logic                            l2_ack_ready_o,
  // Status
  output logic                            full_o,
  output logic [wbb_pkg::WBB_CNT_W-1:0]   free_entries_o
);

  // Controller strobes
  logic add_entry;
  logic switch_entry;
  logic mark_wait;
  logic clear_entry;
  logic wake_entry;
  // Buffer status
  logic line_hit;
  logic tag_hit;
  logic req_available;

  wbb_ctrl u_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .evict_valid_i   (evict_valid_i),
    .l2_ack_valid_i  (l2_ack_valid_i),
    .l2_ack_retry_i  (l2_ack_retry_i),
    .l2_req_ready_i  (l2_req_ready_i),
    .line_hit_i      (line_hit),
    .tag_hit_i       (tag_hit),
    .req_available_i (req_available),
    .full_i          (full_o),
    .evict_ready_o   (evict_ready_o),
    .l2_ack_ready_o  (l2_ack_ready_o),
    .l2_req_valid_o  (l2_req_valid_o),
    .add_entry_o     (add_entry),
    .switch_entry_o  (switch_entry),
    .mark_wait_o     (mark_wait),
    .clear_entry_o   (clear_entry),
    .wake_entry_o    (wake_entry)
  );

  // Advances exactly when a request is accepted
  wbb_tag_counter u_tag_counter (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .advance_i (mark_wait),
    .tag_o     (l2_req_tag_o)
  );

  wbb_victim_buffer u_buffer (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .add_entry_i     (add_entry),
    .switch_entry_i  (switch_entry),
    .mark_wait_i     (mark_wait),
    .clear_entry_i   (clear_entry),
    .wake_entry_i    (wake_entry),
    .new_tag_i       (l2_req_tag_o),
    .evict_addr_i    (evict_addr_i),
    .evict_line_i    (evict_line_i),
    .ack_tag_i       (l2_ack_tag_i),
    .lookup_addr_i   (lookup_addr_i),
    .req_line_o      (l2_req_line_o),
    .req_addr_o      (l2_req_addr_o),
    .lookup_line_o   (lookup_line_o),
    .lookup_hit_o    (lookup_hit_o),
    .line_hit_o      (line_hit),
    .tag_hit_o       (tag_hit),
    .req_available_o (req_available),
    .full_o          (full_o),
    .free_entries_o  (free_entries_o)
  );

endmodule

// ==== wbb_vectors.txt ====
// Columns, all hex: cmd sel addr data hit free full
// cmd 1 evict, 2 lookup, 3 ack, 4 ack-retry, 5 drain, 6 blocked evict freed by entry sel, f end
// For acks sel 0 uses the current tag, 1 the stale one
1 0 00000100 a1a1a1a1a1a1a1a1 0 3 0
1 0 00000200 b2b2b2b2b2b2b2b2 0 2 0
1 0 00000300 c3c3c3c3c3c3c3c3 0 1 0
5 0 00000000 0000000000000000 0 1 0
2 0 00000200 b2b2b2b2b2b2b2b2 1 1 0
2 0 00000400 0000000000000000 0 1 0
3 0 00000100 0000000000000000 0 2 0
2 0 00000100 0000000000000000 0 2 0
4 0 00000200 0000000000000000 0 2 0
5 0 00000000 0000000000000000 0 2 0
3 0 00000200 0000000000000000 0 3 0
// Overwrite while in flight, then stale and current acks
1 0 00000300 c4c4c4c4c4c4c4c4 0 3 0
2 0 00000300 c4c4c4c4c4c4c4c4 1 3 0
3 1 00000300 0000000000000000 0 3 0
3 0 00000300 0000000000000000 0 4 0
// Fill up, tags wrap on the fourth
1 0 00000500 d5d5d5d5d5d5d5d5 0 3 0
1 0 00000600 e6e6e6e6e6e6e6e6 0 2 0
1 0 00000700 f7f7f7f7f7f7f7f7 0 1 0
1 0 00000800 0808080808080808 0 0 1
5 0 00000000 0000000000000000 0 0 1
1 0 00000600 e7e7e7e7e7e7e7e7 0 0 1
5 0 00000000 0000000000000000 0 0 1
6 0 00000900 9999999999999999 0 0 1
2 0 00000900 9999999999999999 1 0 1
2 0 00000500 0000000000000000 0 0 1
f 0 00000000 0000000000000000 0 0 0

// ==== wbb_victim_buffer.sv ====
// At most one strobe per cycle is assumed; buffered addresses are unique, lookup is combinational
`timescale 1ns/100ps

module wbb_victim_buffer (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // Strobes from the controller, one-hot or none
  input  logic                            add_entry_i,
  input  logic                            switch_entry_i,
  input  logic                            mark_wait_i,
  input  logic                            clear_entry_i,
  input  logic                            wake_entry_i,
  // Tag given to the entry being sent
  input  logic [wbb_pkg::WBB_TAG_W-1:0]   new_tag_i,
  // Incoming victim line
  input  logic [wbb_pkg::LINE_ADDR_W-1:0] evict_addr_i,
  input  logic [wbb_pkg::LINE_W-1:0]      evict_line_i,
  // Tag of the L2 acknowledge
  input  logic [wbb_pkg::WBB_TAG_W-1:0]   ack_tag_i,
  // Cache miss lookup
  input  logic [wbb_pkg::LINE_ADDR_W-1:0] lookup_addr_i,
  // Next request contents
  output logic [wbb_pkg::LINE_W-1:0]      req_line_o,
  output logic [wbb_pkg::LINE_ADDR_W-1:0] req_addr_o,
  // Lookup result
  output logic [wbb_pkg::LINE_W-1:0]      lookup_line_o,
  output logic                            lookup_hit_o,
  // Status back to the controller
  output logic                            line_hit_o,
  output logic                            tag_hit_o,
  output logic                            req_available_o,
  output logic                            full_o,
  output logic [wbb_pkg::WBB_CNT_W-1:0]   free_entries_o
);

  // Entry payload
  logic [wbb_pkg::LINE_W-1:0]      line_q [wbb_pkg::WBB_ENTRIES];
  logic [wbb_pkg::LINE_ADDR_W-1:0] addr_q [wbb_pkg::WBB_ENTRIES];
  logic [wbb_pkg::WBB_TAG_W-1:0]   tag_q  [wbb_pkg::WBB_ENTRIES];
  // Entry state, wait implies valid
  logic [wbb_pkg::WBB_ENTRIES-1:0] valid_q;
  logic [wbb_pkg::WBB_ENTRIES-1:0] wait_q;

  // Per-entry match vectors
  logic [wbb_pkg::WBB_ENTRIES-1:0] line_hit_vec;
  logic [wbb_pkg::WBB_ENTRIES-1:0] tag_hit_vec;
  logic [wbb_pkg::WBB_ENTRIES-1:0] lookup_hit_vec;
  logic [wbb_pkg::WBB_ENTRIES-1:0] hit_vec;
  logic [wbb_pkg::WBB_ENTRIES-1:0] free_vec;
  logic [wbb_pkg::WBB_ENTRIES-1:0] send_vec;

  // Selected entries
  logic [wbb_pkg::WBB_IDX_W-1:0] free_idx;
  logic [wbb_pkg::WBB_IDX_W-1:0] req_idx;
  logic [wbb_pkg::WBB_IDX_W-1:0] hit_idx;

  // Comparators
  always_comb begin
    for (int k = 0; k < wbb_pkg::WBB_ENTRIES; k++) begin
      // Eviction address against live entries
      line_hit_vec[k]   = valid_q[k] && (addr_q[k] == evict_addr_i);
      // Only a waiting entry owns its tag, otherwise the tag is stale
      tag_hit_vec[k]    = wait_q[k] && (tag_q[k] == ack_tag_i);
      lookup_hit_vec[k] = valid_q[k] && (addr_q[k] == lookup_addr_i);
    end
  end

  assign free_vec = ~valid_q;
  // Sendable: holds data and no request in flight
  assign send_vec = valid_q & ~wait_q;
  // Ack strobes select by tag, the rest by address
  assign hit_vec  = (clear_entry_i || wake_entry_i) ? tag_hit_vec : line_hit_vec;

  wbb_prio_encoder #(
    .WIDTH (wbb_pkg::WBB_ENTRIES),
    .IDX_W (wbb_pkg::WBB_IDX_W)
  ) u_free_enc (
    .vec_i (free_vec),
    .idx_o (free_idx)
  );

  wbb_prio_encoder #(
    .WIDTH (wbb_pkg::WBB_ENTRIES),
    .IDX_W (wbb_pkg::WBB_IDX_W)
  ) u_req_enc (
    .vec_i (send_vec),
    .idx_o (req_idx)
  );

  wbb_prio_encoder #(
    .WIDTH (wbb_pkg::WBB_ENTRIES),
    .IDX_W (wbb_pkg::WBB_IDX_W)
  ) u_hit_enc (
    .vec_i (hit_vec),
    .idx_o (hit_idx)
  );

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (add_entry_i) begin
      line_q[free_idx] <= evict_line_i;
      addr_q[free_idx] <= evict_addr_i;
    end
    // Same address, so only the data changes
    if (switch_entry_i) begin
      line_q[hit_idx] <= evict_line_i;
    end
    if (mark_wait_i) begin
      tag_q[req_idx] <= new_tag_i;
    end
  end

  // Valid and wait bits
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      wait_q  <= '0;
    end else if (add_entry_i) begin
      valid_q[free_idx] <= 1'b1;
      wait_q[free_idx]  <= 1'b0;
    end else if (mark_wait_i) begin
      wait_q[req_idx] <= 1'b1;
    end else if (clear_entry_i) begin
      valid_q[hit_idx] <= 1'b0;
      wait_q[hit_idx]  <= 1'b0;
    end else if (switch_entry_i || wake_entry_i) begin
      // New data or a retry, either way the entry must be sent again
      wait_q[hit_idx] <= 1'b0;
    end
  end

  assign req_line_o = line_q[req_idx];
  assign req_addr_o = addr_q[req_idx];

  // Addresses are unique, so at most one entry matches
  always_comb begin
    lookup_line_o = '0;
    for (int k = 0; k < wbb_pkg::WBB_ENTRIES; k++) begin
      if (lookup_hit_vec[k]) begin
        lookup_line_o = line_q[k];
      end
    end
  end

  assign lookup_hit_o    = |lookup_hit_vec;
  assign line_hit_o      = |line_hit_vec;
  assign tag_hit_o       = |tag_hit_vec;
  assign req_available_o = |send_vec;
  assign full_o          = &valid_q;

  // Population count of free entries
  always_comb begin
    free_entries_o = '0;
    for (int k = 0; k < wbb_pkg::WBB_ENTRIES; k++) begin
      free_entries_o = free_entries_o + {{(wbb_pkg::WBB_CNT_W - 1){1'b0}}, free_vec[k]};
    end
  end

endmodule
